//--- source/noc_bridge_pkg.sv
package noc_bridge_pkg;

  // AXI widths
  localparam int axi_id_w    = 8;
  localparam int axi_addr_w  = 32;
  localparam int axi_data_w  = 64;
  localparam int axi_strb_w  = 8;
  localparam int axi_len_w   = 8;
  localparam int axi_size_w  = 3;
  localparam int axi_burst_w = 2;
  localparam int axi_resp_w  = 2;

  // Flit widths, header is valid + tail + dst + vc
  localparam int flit_dst_w  = 2;
  localparam int flit_data_w = 92;
  localparam int flit_w      = flit_data_w + 5;

  typedef logic [axi_id_w-1:0]    axi_id_t;
  typedef logic [axi_addr_w-1:0]  axi_addr_t;
  typedef logic [axi_data_w-1:0]  axi_data_t;
  typedef logic [axi_strb_w-1:0]  axi_strb_t;
  typedef logic [axi_len_w-1:0]   axi_len_t;
  typedef logic [axi_size_w-1:0]  axi_size_t;
  typedef logic [axi_burst_w-1:0] axi_burst_t;
  typedef logic [axi_resp_w-1:0]  axi_resp_t;

  typedef logic [flit_dst_w-1:0]  flit_dst_t;
  typedef logic [flit_data_w-1:0] flit_data_t;
  typedef logic [flit_w-1:0]      flit_t;

  typedef enum logic [2:0] {
    chan_aw = 3'd0,
    chan_w  = 3'd1,
    chan_b  = 3'd2,
    chan_ar = 3'd3,
    chan_r  = 3'd4
  } flit_channel_t;

  // Header bits above the data field
  localparam int flit_valid_bit = flit_w - 1;
  localparam int flit_tail_bit  = flit_w - 2;
  localparam int flit_dst_hi    = flit_w - 3;
  localparam int flit_dst_lo    = flit_w - 4;
  localparam int flit_vc_bit    = flit_w - 5;

  // Data field layout
  localparam int fld_chan_hi  = 91;
  localparam int fld_chan_lo  = 89;
  localparam int fld_id_hi    = 80;
  localparam int fld_id_lo    = 73;
  localparam int fld_last_bit = 72;
  localparam int fld_strb_hi  = 71;
  localparam int fld_strb_lo  = 64;
  // resp shares the low strb bits
  localparam int fld_resp_hi  = 65;
  localparam int fld_resp_lo  = 64;
  localparam int fld_data_hi  = 63;
  localparam int fld_data_lo  = 0;
  localparam int fld_len_hi   = 60;
  localparam int fld_len_lo   = 53;
  localparam int fld_size_hi  = 52;
  localparam int fld_size_lo  = 50;
  localparam int fld_burst_hi = 49;
  localparam int fld_burst_lo = 48;
  localparam int fld_addr_hi  = 31;
  localparam int fld_addr_lo  = 0;

  // Virtual channels
  localparam logic vc_request  = 1'b1;
  localparam logic vc_response = 1'b0;

endpackage

//--- source/flit_tx_header.sv
`timescale 1ns/1ps

module flit_tx_header
  import noc_bridge_pkg::*;
#(
  parameter logic vc = 1'b0
) (
  input  logic       CLK,
  input  logic       RST_N,
  input  logic       start,
  input  flit_dst_t  start_dst,
  input  logic       send,
  input  logic       tail,
  input  flit_data_t data,
  output flit_t      flit,
  output logic       flit_valid
);

  flit_dst_t dst_q;
  flit_dst_t dst;

  // Destination held for the rest of the transaction
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      dst_q <= '0;
    end else if (start) begin
      dst_q <= start_dst;
    end
  end

  // First flit of a transaction goes out before dst_q is loaded
  assign dst = start ? start_dst : dst_q;

  always_comb begin
    flit                             = '0;
    flit[flit_valid_bit]             = send;
    flit[flit_tail_bit]              = tail;
    flit[flit_dst_hi:flit_dst_lo]    = dst;
    flit[flit_vc_bit]                = vc;
    flit[flit_data_w-1:0]            = data;
  end

  assign flit_valid = send;

endmodule

//--- source/axi_master_bridge.sv
`timescale 1ns/1ps

module axi_master_bridge
  import noc_bridge_pkg::*;
(
  input  logic       CLK,
  input  logic       RST_N,
  // AXI slave port
  input  logic       s_awvalid,
  output logic       s_awready,
  input  axi_id_t    s_awid,
  input  axi_addr_t  s_awaddr,
  input  axi_len_t   s_awlen,
  input  axi_size_t  s_awsize,
  input  axi_burst_t s_awburst,
  input  logic       s_wvalid,
  output logic       s_wready,
  input  axi_data_t  s_wdata,
  input  axi_strb_t  s_wstrb,
  input  logic       s_wlast,
  output logic       s_bvalid,
  input  logic       s_bready,
  output axi_id_t    s_bid,
  output axi_resp_t  s_bresp,
  input  logic       s_arvalid,
  output logic       s_arready,
  input  axi_id_t    s_arid,
  input  axi_addr_t  s_araddr,
  input  axi_len_t   s_arlen,
  input  axi_size_t  s_arsize,
  input  axi_burst_t s_arburst,
  output logic       s_rvalid,
  input  logic       s_rready,
  output axi_id_t    s_rid,
  output axi_data_t  s_rdata,
  output axi_resp_t  s_rresp,
  output logic       s_rlast,
  // Flit ports
  output flit_t      put_flit,
  output logic       put_valid,
  input  flit_t      get_flit,
  input  logic       get_valid,
  output logic       get_ready
);

  typedef enum logic [2:0] {
    st_idle,
    st_wdata,
    st_wresp_wait,
    st_wresp,
    st_rdata_wait,
    st_rdata
  } state_t;

  state_t     state;
  state_t     state_nxt;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       ar_fire;
  logic       r_fire;
  flit_t      get_q;
  flit_data_t put_data;

  assign aw_fire = s_awvalid && s_awready;
  assign w_fire  = s_wvalid && s_wready;
  assign b_fire  = s_bvalid && s_bready;
  assign ar_fire = s_arvalid && s_arready;
  assign r_fire  = s_rvalid && s_rready;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (aw_fire) begin
          state_nxt = st_wdata;
        end else if (ar_fire) begin
          state_nxt = st_rdata_wait;
        end
      end
      st_wdata:      if (w_fire && s_wlast) state_nxt = st_wresp_wait;
      st_wresp_wait: if (get_valid) state_nxt = st_wresp;
      st_wresp:      if (b_fire) state_nxt = st_idle;
      st_rdata_wait: if (get_valid) state_nxt = st_rdata;
      st_rdata: begin
        if (r_fire) begin
          state_nxt = s_rlast ? st_idle : st_rdata_wait;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  // aw wins when both address channels are valid in idle
  assign s_awready = (state == st_idle);
  assign s_arready = (state == st_idle) && !s_awvalid;
  assign s_wready  = (state == st_wdata);

  // Request flit payload
  always_comb begin
    put_data = '0;
    if (aw_fire) begin
      put_data[fld_chan_hi:fld_chan_lo]   = chan_aw;
      put_data[fld_id_hi:fld_id_lo]       = s_awid;
      put_data[fld_len_hi:fld_len_lo]     = s_awlen;
      put_data[fld_size_hi:fld_size_lo]   = s_awsize;
      put_data[fld_burst_hi:fld_burst_lo] = s_awburst;
      put_data[fld_addr_hi:fld_addr_lo]   = s_awaddr;
    end else if (w_fire) begin
      put_data[fld_chan_hi:fld_chan_lo]   = chan_w;
      put_data[fld_last_bit]              = s_wlast;
      put_data[fld_strb_hi:fld_strb_lo]   = s_wstrb;
      put_data[fld_data_hi:fld_data_lo]   = s_wdata;
    end else if (ar_fire) begin
      put_data[fld_chan_hi:fld_chan_lo]   = chan_ar;
      put_data[fld_id_hi:fld_id_lo]       = s_arid;
      put_data[fld_len_hi:fld_len_lo]     = s_arlen;
      put_data[fld_size_hi:fld_size_lo]   = s_arsize;
      put_data[fld_burst_hi:fld_burst_lo] = s_arburst;
      put_data[fld_addr_hi:fld_addr_lo]   = s_araddr;
    end
  end

  flit_tx_header #(
    .vc(vc_request)
  ) u_tx_header (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .start      (aw_fire || ar_fire),
    .start_dst  (aw_fire ? s_awaddr[flit_dst_w-1:0] : s_araddr[flit_dst_w-1:0]),
    .send       (aw_fire || w_fire || ar_fire),
    .tail       (ar_fire || (w_fire && s_wlast)),
    .data       (put_data),
    .flit       (put_flit),
    .flit_valid (put_valid)
  );

  // Response flit register
  assign get_ready = (state == st_wresp_wait) || (state == st_rdata_wait);

  always_ff @(posedge CLK) begin
    if (get_ready) begin
      get_q <= get_flit;
    end
  end

  assign s_bvalid = (state == st_wresp);
  assign s_bid    = get_q[fld_id_hi:fld_id_lo];
  assign s_bresp  = get_q[fld_resp_hi:fld_resp_lo];

  assign s_rvalid = (state == st_rdata);
  assign s_rid    = get_q[fld_id_hi:fld_id_lo];
  assign s_rdata  = get_q[fld_data_hi:fld_data_lo];
  assign s_rresp  = get_q[fld_resp_hi:fld_resp_lo];
  assign s_rlast  = get_q[fld_last_bit];

endmodule

//--- source/axi_slave_bridge.sv
`timescale 1ns/1ps

module axi_slave_bridge
  import noc_bridge_pkg::*;
(
  input  logic       CLK,
  input  logic       RST_N,
  // AXI master port
  output logic       m_awvalid,
  input  logic       m_awready,
  output axi_id_t    m_awid,
  output axi_addr_t  m_awaddr,
  output axi_len_t   m_awlen,
  output axi_size_t  m_awsize,
  output axi_burst_t m_awburst,
  output logic       m_wvalid,
  input  logic       m_wready,
  output axi_data_t  m_wdata,
  output axi_strb_t  m_wstrb,
  output logic       m_wlast,
  input  logic       m_bvalid,
  output logic       m_bready,
  input  axi_id_t    m_bid,
  input  axi_resp_t  m_bresp,
  output logic       m_arvalid,
  input  logic       m_arready,
  output axi_id_t    m_arid,
  output axi_addr_t  m_araddr,
  output axi_len_t   m_arlen,
  output axi_size_t  m_arsize,
  output axi_burst_t m_arburst,
  input  logic       m_rvalid,
  output logic       m_rready,
  input  axi_id_t    m_rid,
  input  axi_data_t  m_rdata,
  input  axi_resp_t  m_rresp,
  input  logic       m_rlast,
  // Flit ports
  output flit_t      put_flit,
  output logic       put_valid,
  input  flit_t      get_flit,
  input  logic       get_valid,
  output logic       get_ready
);

  typedef enum logic [2:0] {
    st_idle,
    st_waddr,
    st_wdata_wait,
    st_wdata,
    st_wresp,
    st_raddr,
    st_rdata
  } state_t;

  state_t        state;
  state_t        state_nxt;
  logic          aw_fire;
  logic          w_fire;
  logic          b_fire;
  logic          ar_fire;
  logic          r_fire;
  flit_channel_t in_chan;
  flit_t         get_q;
  flit_data_t    put_data;

  assign aw_fire = m_awvalid && m_awready;
  assign w_fire  = m_wvalid && m_wready;
  assign b_fire  = m_bvalid && m_bready;
  assign ar_fire = m_arvalid && m_arready;
  assign r_fire  = m_rvalid && m_rready;

  // Channel of the flit currently offered by the network
  assign in_chan = flit_channel_t'(get_flit[fld_chan_hi:fld_chan_lo]);

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (get_valid && in_chan == chan_aw) begin
          state_nxt = st_waddr;
        end else if (get_valid && in_chan == chan_ar) begin
          state_nxt = st_raddr;
        end
      end
      st_waddr:      if (aw_fire) state_nxt = st_wdata_wait;
      st_wdata_wait: if (get_valid) state_nxt = st_wdata;
      st_wdata: begin
        if (w_fire) begin
          state_nxt = m_wlast ? st_wresp : st_wdata_wait;
        end
      end
      st_wresp:      if (b_fire) state_nxt = st_idle;
      st_raddr:      if (ar_fire) state_nxt = st_rdata;
      st_rdata:      if (r_fire && m_rlast) state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  // Request flit register, frozen while a beat is on the AXI side
  assign get_ready = (state == st_idle) || (state == st_wdata_wait);

  always_ff @(posedge CLK) begin
    if (get_ready) begin
      get_q <= get_flit;
    end
  end

  assign m_awvalid = (state == st_waddr);
  assign m_awid    = get_q[fld_id_hi:fld_id_lo];
  assign m_awaddr  = get_q[fld_addr_hi:fld_addr_lo];
  assign m_awlen   = get_q[fld_len_hi:fld_len_lo];
  assign m_awsize  = get_q[fld_size_hi:fld_size_lo];
  assign m_awburst = get_q[fld_burst_hi:fld_burst_lo];

  assign m_wvalid  = (state == st_wdata);
  assign m_wdata   = get_q[fld_data_hi:fld_data_lo];
  assign m_wstrb   = get_q[fld_strb_hi:fld_strb_lo];
  assign m_wlast   = get_q[fld_last_bit];

  assign m_bready  = (state == st_wresp);

  assign m_arvalid = (state == st_raddr);
  assign m_arid    = get_q[fld_id_hi:fld_id_lo];
  assign m_araddr  = get_q[fld_addr_hi:fld_addr_lo];
  assign m_arlen   = get_q[fld_len_hi:fld_len_lo];
  assign m_arsize  = get_q[fld_size_hi:fld_size_lo];
  assign m_arburst = get_q[fld_burst_hi:fld_burst_lo];

  assign m_rready  = (state == st_rdata);

  // Response flit payload
  always_comb begin
    put_data = '0;
    if (b_fire) begin
      put_data[fld_chan_hi:fld_chan_lo] = chan_b;
      put_data[fld_id_hi:fld_id_lo]     = m_bid;
      put_data[fld_resp_hi:fld_resp_lo] = m_bresp;
    end else if (r_fire) begin
      put_data[fld_chan_hi:fld_chan_lo] = chan_r;
      put_data[fld_id_hi:fld_id_lo]     = m_rid;
      put_data[fld_last_bit]            = m_rlast;
      put_data[fld_resp_hi:fld_resp_lo] = m_rresp;
      put_data[fld_data_hi:fld_data_lo] = m_rdata;
    end
  end

  // Responses route back by the low ID bits
  flit_tx_header #(
    .vc(vc_response)
  ) u_tx_header (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .start      (aw_fire || ar_fire),
    .start_dst  (aw_fire ? m_awid[flit_dst_w-1:0] : m_arid[flit_dst_w-1:0]),
    .send       (b_fire || r_fire),
    .tail       (b_fire || (r_fire && m_rlast)),
    .data       (put_data),
    .flit       (put_flit),
    .flit_valid (put_valid)
  );

endmodule

//--- source/axi_noc_bridge_pair.sv
`timescale 1ns/1ps

module axi_noc_bridge_pair
  import noc_bridge_pkg::*;
(
  input  logic       CLK,
  input  logic       RST_N,
  // AXI slave port, driven by the master device
  input  logic       s_awvalid,
  output logic       s_awready,
  input  axi_id_t    s_awid,
  input  axi_addr_t  s_awaddr,
  input  axi_len_t   s_awlen,
  input  axi_size_t  s_awsize,
  input  axi_burst_t s_awburst,
  input  logic       s_wvalid,
  output logic       s_wready,
  input  axi_data_t  s_wdata,
  input  axi_strb_t  s_wstrb,
  input  logic       s_wlast,
  output logic       s_bvalid,
  input  logic       s_bready,
  output axi_id_t    s_bid,
  output axi_resp_t  s_bresp,
  input  logic       s_arvalid,
  output logic       s_arready,
  input  axi_id_t    s_arid,
  input  axi_addr_t  s_araddr,
  input  axi_len_t   s_arlen,
  input  axi_size_t  s_arsize,
  input  axi_burst_t s_arburst,
  output logic       s_rvalid,
  input  logic       s_rready,
  output axi_id_t    s_rid,
  output axi_data_t  s_rdata,
  output axi_resp_t  s_rresp,
  output logic       s_rlast,
  // AXI master port, toward the slave device
  output logic       m_awvalid,
  input  logic       m_awready,
  output axi_id_t    m_awid,
  output axi_addr_t  m_awaddr,
  output axi_len_t   m_awlen,
  output axi_size_t  m_awsize,
  output axi_burst_t m_awburst,
  output logic       m_wvalid,
  input  logic       m_wready,
  output axi_data_t  m_wdata,
  output axi_strb_t  m_wstrb,
  output logic       m_wlast,
  input  logic       m_bvalid,
  output logic       m_bready,
  input  axi_id_t    m_bid,
  input  axi_resp_t  m_bresp,
  output logic       m_arvalid,
  input  logic       m_arready,
  output axi_id_t    m_arid,
  output axi_addr_t  m_araddr,
  output axi_len_t   m_arlen,
  output axi_size_t  m_arsize,
  output axi_burst_t m_arburst,
  input  logic       m_rvalid,
  output logic       m_rready,
  input  axi_id_t    m_rid,
  input  axi_data_t  m_rdata,
  input  axi_resp_t  m_rresp,
  input  logic       m_rlast,
  // Network links
  output flit_t      req_put_flit,
  output logic       req_put_valid,
  input  flit_t      req_get_flit,
  input  logic       req_get_valid,
  output logic       req_get_ready,
  output flit_t      rsp_put_flit,
  output logic       rsp_put_valid,
  input  flit_t      rsp_get_flit,
  input  logic       rsp_get_valid,
  output logic       rsp_get_ready
);

  // AXI ports connect by name, flit ports map to the request/response links
  axi_master_bridge u_master_bridge (
    .put_flit  (req_put_flit),
    .put_valid (req_put_valid),
    .get_flit  (rsp_get_flit),
    .get_valid (rsp_get_valid),
    .get_ready (rsp_get_ready),
    .*
  );

  axi_slave_bridge u_slave_bridge (
    .put_flit  (rsp_put_flit),
    .put_valid (rsp_put_valid),
    .get_flit  (req_get_flit),
    .get_valid (req_get_valid),
    .get_ready (req_get_ready),
    .*
  );

endmodule

//--- verif/axi_noc_bridge_pair_assertions.sv
`timescale 1ns/1ps

module axi_noc_bridge_pair_assertions
  import noc_bridge_pkg::*;
(
  input logic  CLK,
  input logic  RST_N,
  input flit_t put_flit,
  input logic  put_valid,
  input logic  excl_a,
  input logic  excl_b,
  input logic  hold_valid_a,
  input logic  hold_ready_a,
  input logic  hold_valid_b,
  input logic  hold_ready_b
);

  // Set by any failing assertion below
  bit failed;

  a_flit_valid: assert property (@(posedge CLK) disable iff (!RST_N)
    put_flit[flit_valid_bit] == put_valid)
    else begin
      $error("Flit valid bit differs from put valid");
      failed = 1'b1;
    end

  a_exclusive: assert property (@(posedge CLK) disable iff (!RST_N)
    !(excl_a && excl_b))
    else begin
      $error("aw and w signals high together");
      failed = 1'b1;
    end

  a_hold_a: assert property (@(posedge CLK) disable iff (!RST_N)
    hold_valid_a && !hold_ready_a |=> hold_valid_a)
    else begin
      $error("Valid dropped before its handshake");
      failed = 1'b1;
    end

  a_hold_b: assert property (@(posedge CLK) disable iff (!RST_N)
    hold_valid_b && !hold_ready_b |=> hold_valid_b)
    else begin
      $error("Valid dropped before its handshake");
      failed = 1'b1;
    end

endmodule

bind axi_master_bridge axi_noc_bridge_pair_assertions u_master_assertions (
  .CLK(CLK), .RST_N(RST_N), .put_flit(put_flit), .put_valid(put_valid),
  .excl_a(s_awready), .excl_b(s_wready),
  .hold_valid_a(s_bvalid), .hold_ready_a(s_bready),
  .hold_valid_b(s_rvalid), .hold_ready_b(s_rready)
);

bind axi_slave_bridge axi_noc_bridge_pair_assertions u_slave_assertions (
  .CLK(CLK), .RST_N(RST_N), .put_flit(put_flit), .put_valid(put_valid),
  .excl_a(m_awvalid), .excl_b(m_wvalid),
  .hold_valid_a(m_awvalid), .hold_ready_a(m_awready),
  .hold_valid_b(m_wvalid), .hold_ready_b(m_wready)
);

//--- verif/tb_axi_noc_bridge_pair.sv
`timescale 1ns/1ps

module tb_axi_noc_bridge_pair
  import noc_bridge_pkg::*;
();

  localparam int n_transactions = 14;
  localparam int timeout_cycles = 2000 * n_transactions;

  logic       CLK;
  logic       RST_N;
  logic       s_awvalid, s_awready, s_wvalid, s_wready, s_wlast, s_bvalid, s_bready;
  logic       s_arvalid, s_arready, s_rvalid, s_rready, s_rlast;
  axi_id_t    s_awid, s_bid, s_arid, s_rid;
  axi_addr_t  s_awaddr, s_araddr;
  axi_len_t   s_awlen, s_arlen;
  axi_size_t  s_awsize, s_arsize;
  axi_burst_t s_awburst, s_arburst;
  axi_data_t  s_wdata, s_rdata;
  axi_strb_t  s_wstrb;
  axi_resp_t  s_bresp, s_rresp;
  logic       m_awvalid, m_awready, m_wvalid, m_wready, m_wlast, m_bvalid, m_bready;
  logic       m_arvalid, m_arready, m_rvalid, m_rready, m_rlast;
  axi_id_t    m_awid, m_bid, m_arid, m_rid;
  axi_addr_t  m_awaddr, m_araddr;
  axi_len_t   m_awlen, m_arlen;
  axi_size_t  m_awsize, m_arsize;
  axi_burst_t m_awburst, m_arburst;
  axi_data_t  m_wdata, m_rdata;
  axi_strb_t  m_wstrb;
  axi_resp_t  m_bresp, m_rresp;
  flit_t      req_put_flit, req_get_flit, rsp_put_flit, rsp_get_flit;
  logic       req_put_valid, req_get_valid, req_get_ready;
  logic       rsp_put_valid, rsp_get_valid, rsp_get_ready;

  // Network and device model state
  logic [31:0] lcg_state = 32'd17483;
  logic        stall_en;
  flit_t       req_q[$], rsp_q[$], req_log[$], rsp_log[$];
  int          req_wait, rsp_wait;
  axi_data_t   dev_mem[axi_addr_t];
  axi_data_t   exp_mem[axi_addr_t];
  axi_addr_t   dev_wword, dev_rword;
  axi_id_t     dev_wid, dev_rid;
  int          dev_rleft;
  axi_id_t     seen_awid;
  axi_addr_t   seen_awaddr;
  axi_len_t    seen_awlen;
  axi_size_t   seen_awsize;
  axi_burst_t  seen_awburst;
  axi_size_t   seen_arsize;
  axi_burst_t  seen_arburst;
  axi_data_t   seen_wdata[$];
  axi_strb_t   seen_wstrb[$];

  axi_noc_bridge_pair u_dut (.*);

  always #5 CLK = ~CLK;

  function automatic logic [31:0] lcg();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int net_delay();
    return stall_en ? int'((lcg() >> 16) % 5) : 0;
  endfunction

  function automatic logic ready_draw();
    return stall_en ? ((lcg() >> 16) % 3 != 0) : 1'b1;
  endfunction

  // Unwritten words read back a pattern built from the full word address
  function automatic axi_data_t fill_word(axi_addr_t w);
    return {w ^ 32'h5a5a_0000, ~w};
  endfunction

  function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t nw, axi_strb_t strb);
    axi_data_t r;
    r = old;
    for (int i = 0; i < axi_strb_w; i++) begin
      if (strb[i]) r[8*i +: 8] = nw[8*i +: 8];
    end
    return r;
  endfunction

  function automatic axi_data_t expected_word(axi_addr_t w);
    return exp_mem.exists(w) ? exp_mem[w] : fill_word(w);
  endfunction

  function automatic axi_data_t device_word(axi_addr_t w);
    return dev_mem.exists(w) ? dev_mem[w] : fill_word(w);
  endfunction

  function automatic logic assertions_failed();
    return u_dut.u_master_bridge.u_master_assertions.failed ||
           u_dut.u_slave_bridge.u_slave_assertions.failed;
  endfunction

  task automatic check_value(input string what, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "Check mismatch");
    end
  endtask

  // Bound checkers on both bridges
  always @(posedge CLK) begin
    if (assertions_failed()) begin
      $display("A bound bridge assertion failed");
      $display("Regression failed");
      $fatal(1, "Assertion failure");
    end
  end

  // Request link from the master bridge to the slave bridge
  always @(posedge CLK) begin
    if (!RST_N) begin
      req_q.delete();
      req_get_valid <= 1'b0;
      req_wait = 0;
    end else begin
      if (req_put_valid) begin
        req_q.push_back(req_put_flit);
        req_log.push_back(req_put_flit);
      end
      if (req_get_valid && req_get_ready) begin
        void'(req_q.pop_front());
        req_get_valid <= 1'b0;
        req_wait = net_delay();
      end else if (!req_get_valid && req_q.size() > 0) begin
        if (req_wait == 0) begin
          req_get_flit  <= req_q[0];
          req_get_valid <= 1'b1;
        end else begin
          req_wait = req_wait - 1;
        end
      end
    end
  end

  // Response link from the slave bridge to the master bridge
  always @(posedge CLK) begin
    if (!RST_N) begin
      rsp_q.delete();
      rsp_get_valid <= 1'b0;
      rsp_wait = 0;
    end else begin
      if (rsp_put_valid) begin
        rsp_q.push_back(rsp_put_flit);
        rsp_log.push_back(rsp_put_flit);
      end
      if (rsp_get_valid && rsp_get_ready) begin
        void'(rsp_q.pop_front());
        rsp_get_valid <= 1'b0;
        rsp_wait = net_delay();
      end else if (!rsp_get_valid && rsp_q.size() > 0) begin
        if (rsp_wait == 0) begin
          rsp_get_flit  <= rsp_q[0];
          rsp_get_valid <= 1'b1;
        end else begin
          rsp_wait = rsp_wait - 1;
        end
      end
    end
  end

  // Memory device on the AXI master port
  always @(posedge CLK) begin
    if (!RST_N) begin
      m_awready <= 1'b0;
      m_wready  <= 1'b0;
      m_arready <= 1'b0;
      m_bvalid  <= 1'b0;
      m_rvalid  <= 1'b0;
      dev_rleft = 0;
    end else begin
      m_awready <= ready_draw();
      m_wready  <= ready_draw();
      m_arready <= ready_draw();
      if (m_awvalid && m_awready) begin
        dev_wword    = m_awaddr >> 3;
        dev_wid      = m_awid;
        seen_awid    = m_awid;
        seen_awaddr  = m_awaddr;
        seen_awlen   = m_awlen;
        seen_awsize  = m_awsize;
        seen_awburst = m_awburst;
      end
      if (m_wvalid && m_wready) begin
        dev_mem[dev_wword] = merge_bytes(device_word(dev_wword), m_wdata, m_wstrb);
        dev_wword = dev_wword + 1;
        seen_wdata.push_back(m_wdata);
        seen_wstrb.push_back(m_wstrb);
        if (m_wlast) begin
          m_bvalid <= 1'b1;
          m_bid    <= dev_wid;
          m_bresp  <= 2'b00;
        end
      end
      if (m_bvalid && m_bready) m_bvalid <= 1'b0;
      if (m_arvalid && m_arready) begin
        dev_rword    = m_araddr >> 3;
        dev_rid      = m_arid;
        dev_rleft    = int'(m_arlen) + 1;
        seen_arsize  = m_arsize;
        seen_arburst = m_arburst;
      end
      if (!(m_rvalid && !m_rready)) begin
        if (dev_rleft > 0) begin
          m_rvalid  <= 1'b1;
          m_rid     <= dev_rid;
          m_rdata   <= device_word(dev_rword);
          m_rresp   <= 2'b00;
          m_rlast   <= (dev_rleft == 1);
          dev_rword = dev_rword + 1;
          dev_rleft = dev_rleft - 1;
        end else begin
          m_rvalid <= 1'b0;
        end
      end
    end
  end

  task automatic axi_write(input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                           input axi_strb_t strb, input axi_data_t beats[$],
                           output axi_id_t bid, output axi_resp_t bresp);
    axi_addr_t word;
    logic      got;
    word = addr >> 3;
    got  = 1'b0;
    @(posedge CLK);
    s_awvalid <= 1'b1;
    s_awid    <= id;
    s_awaddr  <= addr;
    s_awlen   <= len;
    s_awsize  <= 3'd3;
    s_awburst <= 2'b01;
    do @(posedge CLK); while (!s_awready);
    s_awvalid <= 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      s_wvalid <= 1'b1;
      s_wdata  <= beats[i];
      s_wstrb  <= strb;
      s_wlast  <= (i == int'(len));
      do @(posedge CLK); while (!s_wready);
      exp_mem[word + i] = merge_bytes(expected_word(word + i), beats[i], strb);
    end
    s_wvalid <= 1'b0;
    s_wlast  <= 1'b0;
    s_bready <= ready_draw();
    while (!got) begin
      @(posedge CLK);
      if (s_bvalid && s_bready) begin
        got   = 1'b1;
        bid   = s_bid;
        bresp = s_bresp;
      end
      s_bready <= got ? 1'b0 : ready_draw();
    end
  endtask

  // Read burst with each beat compared against the reference memory
  task automatic axi_read(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
    axi_addr_t word;
    int        beat;
    logic      done;
    word = addr >> 3;
    beat = 0;
    done = 1'b0;
    @(posedge CLK);
    s_arvalid <= 1'b1;
    s_arid    <= id;
    s_araddr  <= addr;
    s_arlen   <= len;
    s_arsize  <= 3'd3;
    s_arburst <= 2'b01;
    do @(posedge CLK); while (!s_arready);
    s_arvalid <= 1'b0;
    s_rready  <= ready_draw();
    while (!done) begin
      @(posedge CLK);
      if (s_rvalid && s_rready) begin
        check_value("rid", s_rid, id);
        check_value("rdata", s_rdata, expected_word(word + beat));
        check_value("rresp", s_rresp, 2'b00);
        check_value("rlast", s_rlast, beat == int'(len));
        done = s_rlast;
        beat++;
      end
      s_rready <= done ? 1'b0 : ready_draw();
    end
  endtask

  task automatic check_rsp_routing(input axi_id_t id);
    foreach (rsp_log[i]) begin
      check_value("response dst", rsp_log[i][flit_dst_hi:flit_dst_lo], id[1:0]);
      check_value("response vc", rsp_log[i][flit_vc_bit], vc_response);
    end
  endtask

  task automatic test_reset();
    check_value("s_awready", s_awready, 1'b1);
    check_value("s_arready", s_arready, 1'b1);
    check_value("s_wready", s_wready, 1'b0);
    check_value("s_bvalid", s_bvalid, 1'b0);
    check_value("s_rvalid", s_rvalid, 1'b0);
    check_value("rsp_get_ready", rsp_get_ready, 1'b0);
    check_value("req_get_ready", req_get_ready, 1'b1);
    check_value("m_awvalid", m_awvalid, 1'b0);
    check_value("m_arvalid", m_arvalid, 1'b0);
    check_value("m_wvalid", m_wvalid, 1'b0);
    check_value("m_bready", m_bready, 1'b0);
    check_value("m_rready", m_rready, 1'b0);
    check_value("req_put_valid", req_put_valid, 1'b0);
    check_value("rsp_put_valid", rsp_put_valid, 1'b0);
  endtask

  task automatic test_single_write();
    axi_data_t beats[$];
    axi_id_t   bid;
    axi_resp_t bresp;
    beats = '{64'h0123_4567_89ab_cdef};
    req_log.delete();
    rsp_log.delete();
    seen_wdata.delete();
    seen_wstrb.delete();
    axi_write(8'd5, 32'h0000_1002, 8'd0, 8'h0f, beats, bid, bresp);
    check_value("request flit count", req_log.size(), 2);
    check_value("aw flit dst", req_log[0][flit_dst_hi:flit_dst_lo], 2'd2);
    check_value("aw flit vc", req_log[0][flit_vc_bit], 1'b1);
    check_value("aw flit tail", req_log[0][flit_tail_bit], 1'b0);
    check_value("w flit dst", req_log[1][flit_dst_hi:flit_dst_lo], 2'd2);
    check_value("w flit tail", req_log[1][flit_tail_bit], 1'b1);
    check_value("slave awid", seen_awid, 8'd5);
    check_value("slave awaddr", seen_awaddr, 32'h0000_1002);
    check_value("slave awlen", seen_awlen, 8'd0);
    check_value("slave awsize", seen_awsize, 3'd3);
    check_value("slave awburst", seen_awburst, 2'b01);
    check_value("slave w beats", seen_wdata.size(), 1);
    check_value("slave wdata", seen_wdata[0], beats[0]);
    check_value("slave wstrb", seen_wstrb[0], 8'h0f);
    check_value("bid", bid, 8'd5);
    check_value("bresp", bresp, 2'b00);
    check_value("b flit count", rsp_log.size(), 1);
    check_value("b flit tail", rsp_log[0][flit_tail_bit], 1'b1);
    check_rsp_routing(8'd5);
  endtask

  task automatic test_read_burst();
    for (int i = 0; i < 4; i++) begin
      dev_mem[32'h400 + i] = 64'hfeed_0000_0000_0000 + i;
      exp_mem[32'h400 + i] = 64'hfeed_0000_0000_0000 + i;
    end
    req_log.delete();
    rsp_log.delete();
    axi_read(8'd3, 32'h0000_2000, 8'd3);
    check_value("slave arsize", seen_arsize, 3'd3);
    check_value("slave arburst", seen_arburst, 2'b01);
    check_value("ar flit count", req_log.size(), 1);
    check_value("ar flit tail", req_log[0][flit_tail_bit], 1'b1);
    check_value("r flit count", rsp_log.size(), 4);
    foreach (rsp_log[i]) check_value("r flit tail", rsp_log[i][flit_tail_bit], i == 3);
    check_rsp_routing(8'd3);
  endtask

  task automatic test_backpressure();
    axi_data_t beats[$];
    axi_id_t   bid;
    axi_resp_t bresp;
    stall_en = 1'b1;
    for (int i = 0; i < 4; i++) beats.push_back({lcg(), lcg()});
    seen_wdata.delete();
    rsp_log.delete();
    axi_write(8'd9, 32'h0000_3001, 8'd3, 8'hff, beats, bid, bresp);
    check_value("slave w beats", seen_wdata.size(), 4);
    check_value("bid", bid, 8'd9);
    rsp_log.delete();
    axi_read(8'd9, 32'h0000_3001, 8'd3);
    check_value("r flit count", rsp_log.size(), 4);
  endtask

  task automatic test_random_mix();
    axi_data_t beats[$];
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
    axi_id_t   bid;
    axi_resp_t bresp;
    for (int n = 0; n < 10; n++) begin
      id   = lcg() >> 24;
      addr = 32'h4000 + ((lcg() >> 16) % 16) * 8 + ((lcg() >> 16) % 4);
      len  = (lcg() >> 16) % 4;
      rsp_log.delete();
      if ((lcg() >> 20) % 2 == 0) begin
        beats.delete();
        for (int i = 0; i <= int'(len); i++) beats.push_back({lcg(), lcg()});
        axi_write(id, addr, len, 8'hff, beats, bid, bresp);
        check_value("bid", bid, id);
      end else begin
        axi_read(id, addr, len);
      end
      check_rsp_routing(id);
    end
  endtask

  initial begin
    CLK       = 1'b0;
    RST_N     = 1'b0;
    stall_en  = 1'b0;
    s_awvalid = 1'b0;
    s_awid    = '0;
    s_awaddr  = '0;
    s_awlen   = '0;
    s_awsize  = '0;
    s_awburst = '0;
    s_wvalid  = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wlast   = 1'b0;
    s_bready  = 1'b0;
    s_arvalid = 1'b0;
    s_arid    = '0;
    s_araddr  = '0;
    s_arlen   = '0;
    s_arsize  = '0;
    s_arburst = '0;
    s_rready  = 1'b0;
    m_awready = 1'b0;
    m_wready  = 1'b0;
    m_bvalid  = 1'b0;
    m_bid     = '0;
    m_bresp   = '0;
    m_arready = 1'b0;
    m_rvalid  = 1'b0;
    m_rid     = '0;
    m_rdata   = '0;
    m_rresp   = '0;
    m_rlast   = 1'b0;
    req_get_flit  = '0;
    req_get_valid = 1'b0;
    rsp_get_flit  = '0;
    rsp_get_valid = 1'b0;
    repeat (10) @(posedge CLK);
    RST_N <= 1'b1;
    @(posedge CLK);
    test_reset();
    test_single_write();
    test_read_burst();
    test_backpressure();
    test_random_mix();
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    if (assertions_failed()) begin
      $display("A bound bridge assertion failed");
      $display("Regression failed");
      $fatal(1, "Assertion failure");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge CLK);
    $display("Watchdog timeout, the tests did not finish in time");
    $display("Regression failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- axi_noc_bridge_pair.f
source/noc_bridge_pkg.sv
source/flit_tx_header.sv
source/axi_master_bridge.sv
source/axi_slave_bridge.sv
source/axi_noc_bridge_pair.sv
verif/axi_noc_bridge_pair_assertions.sv
verif/tb_axi_noc_bridge_pair.sv

//--- Bender.yml
package:
  name: axi_noc_bridge_pair

sources:
  - source/noc_bridge_pkg.sv
  - source/flit_tx_header.sv
  - source/axi_master_bridge.sv
  - source/axi_slave_bridge.sv
  - source/axi_noc_bridge_pair.sv
  - target: simulation
    files:
      - verif/axi_noc_bridge_pair_assertions.sv
      - verif/tb_axi_noc_bridge_pair.sv
